//--- include/fft16_settings.svh
// sizes for the 16-point DIF FFT; the butterfly addressing assumes FFT_N is 16
// no overflow checking, so inputs must leave room for the 16x gain

`ifndef FFT16_SETTINGS_SVH
`define FFT16_SETTINGS_SVH

// transform size
`define FFT_N        16
`define FFT_STAGES   4

// data widths
`define FFT_IN_W     16   // input sample and output word
`define FFT_WORD_W   32   // internal fixed-point word

// fixed-point scaling
`define FFT_IN_SHIFT 8    // fraction bits of the internal word
`define FFT_TW_FRAC  16   // twiddles are Q16.16

`endif

//--- rtl/fft16_pkg.sv
// types and twiddle constants for fft16
// twiddle k is cos(2*pi*k/16) - j*sin(2*pi*k/16), Q16.16

`include "fft16_settings.svh"

package fft16_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [`FFT_IN_W-1:0]   sample_t;
    typedef logic signed [`FFT_WORD_W-1:0] word_t;     // 8 fraction bits
    typedef logic signed [`FFT_IN_W-1:0]   out_word_t;

    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

    typedef cplx_t     [`FFT_N-1:0] frame_t;
    typedef word_t     [`FFT_N-1:0] real_frame_t;
    typedef out_word_t [`FFT_N-1:0] out_frame_t;

    ////////////////////////////////////////////////////////////////////////////
    // twiddle table
    ////////////////////////////////////////////////////////////////////////////

    localparam word_t twiddle_re [`FFT_N/2] = '{
        32'sh0001_0000, 32'sh0000_EC83, 32'sh0000_B504, 32'sh0000_61F7,
        32'sh0000_0000, 32'shFFFF_9E09, 32'shFFFF_4AFC, 32'shFFFF_137D
    };

    // negative sine, so W = re + j*im directly
    localparam word_t twiddle_im [`FFT_N/2] = '{
        32'sh0000_0000, 32'shFFFF_9E09, 32'shFFFF_4AFC, 32'shFFFF_137D,
        32'shFFFF_0000, 32'shFFFF_137D, 32'shFFFF_4AFC, 32'shFFFF_9E09
    };

endpackage

//--- rtl/sample_collector.sv
// gathers 16 real samples into one frame, scaled to 8 fraction bits
// stalls input while a completed frame waits for the engine

`timescale 1ns/1ps

`include "fft16_settings.svh"

module sample_collector
    import fft16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  sample_t     in_data,
    input  logic        in_valid,
    output logic        in_ready,
    output real_frame_t frame,
    output logic        frame_valid,
    input  logic        frame_ready
);

    logic [3:0]  idx;       // next slot
    logic        full;
    real_frame_t frame_q;
    logic        accept;

    assign in_ready    = !full;
    assign accept      = in_valid && in_ready;
    assign frame_valid = full;
    assign frame       = frame_q;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx  <= '0;
            full <= 1'b0;
        end else begin
            if (accept) begin
                idx <= idx + 4'd1;  // wraps to 0 after slot 15
                if (idx == 4'(`FFT_N - 1)) begin
                    full <= 1'b1;
                end
            end
            if (full && frame_ready) begin
                full <= 1'b0;
            end
        end
    end

    // sign-extend, then make room for the fraction bits
    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q[idx] <= word_t'(in_data) <<< `FFT_IN_SHIFT;
        end
    end

endmodule

//--- rtl/butterfly.sv
// radix-2 DIF butterfly, purely combinational
// products are floored to Q.8 by dropping the low 16 bits

`timescale 1ns/1ps

`include "fft16_settings.svh"

module butterfly
    import fft16_pkg::*;
(
    input  cplx_t a,
    input  cplx_t b,
    input  word_t w_re,
    input  word_t w_im,
    output cplx_t sum,
    output cplx_t diff
);

    word_t d_re;
    word_t d_im;

    logic signed [2*`FFT_WORD_W-1:0] p_rr;
    logic signed [2*`FFT_WORD_W-1:0] p_ii;
    logic signed [2*`FFT_WORD_W-1:0] p_ri;
    logic signed [2*`FFT_WORD_W-1:0] p_ir;

    assign d_re = a.re - b.re;
    assign d_im = a.im - b.im;

    assign p_rr = d_re * w_re;
    assign p_ii = d_im * w_im;
    assign p_ri = d_re * w_im;
    assign p_ir = d_im * w_re;

    assign sum.re  = a.re + b.re;
    assign sum.im  = a.im + b.im;

    // (d_re + j*d_im) * (w_re + j*w_im)
    assign diff.re = p_rr[`FFT_TW_FRAC +: `FFT_WORD_W] - p_ii[`FFT_TW_FRAC +: `FFT_WORD_W];
    assign diff.im = p_ri[`FFT_TW_FRAC +: `FFT_WORD_W] + p_ir[`FFT_TW_FRAC +: `FFT_WORD_W];

endmodule

//--- rtl/fft_stage_engine.sv
// in-place 16-point DIF, one stage per cycle through eight butterflies
// result comes out in bit-reversed bin order and holds until taken

`timescale 1ns/1ps

`include "fft16_settings.svh"

module fft_stage_engine
    import fft16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  real_frame_t frame,
    input  logic        frame_valid,
    output logic        frame_ready,
    output frame_t      res,
    output logic        res_valid,
    input  logic        res_ready
);

    localparam int NBF = `FFT_N / 2;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } state_t;

    state_t     state;
    logic [1:0] stg;        // stage 0..3
    logic       rd_sel;     // buffer holding the latest data
    logic       load;

    frame_t     buf_q [2];
    frame_t     cur;
    frame_t     load_frame;
    frame_t     stage_out;

    logic [3:0] span;
    logic [3:0] ia     [NBF];
    logic [3:0] ib     [NBF];
    logic [2:0] tw     [NBF];
    cplx_t      bf_sum [NBF];
    cplx_t      bf_diff[NBF];

    assign frame_ready = (state == IDLE) || (state == HOLD && res_ready);
    assign load        = frame_valid && frame_ready;
    assign res_valid   = (state == HOLD);
    assign cur         = buf_q[rd_sel];
    assign res         = cur;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            stg    <= '0;
            rd_sel <= 1'b0;
        end else if (load) begin
            state  <= RUN;
            stg    <= '0;
            rd_sel <= 1'b0;
        end else begin
            case (state)
                RUN: begin
                    rd_sel <= ~rd_sel;
                    stg    <= stg + 2'd1;
                    if (stg == 2'(`FFT_STAGES - 1)) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (res_ready) begin
                        state <= IDLE;  // result gone, nothing waiting
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pair addressing
    ////////////////////////////////////////////////////////////////////////////

    assign span = 4'(NBF >> stg);   // 8, 4, 2, 1

    always_comb begin
        logic [3:0] lo;
        for (int j = 0; j < NBF; j++) begin
            lo    = 4'(j) & (span - 4'd1);
            ia[j] = ((4'(j) - lo) << 1) | lo;
            ib[j] = ia[j] + span;
            tw[j] = 3'(lo << stg);  // (i mod span) * (8 / span)
        end
    end

    for (genvar j = 0; j < NBF; j++) begin : g_bf
        butterfly i_bf (
            .a    (cur[ia[j]]),
            .b    (cur[ib[j]]),
            .w_re (twiddle_re[tw[j]]),
            .w_im (twiddle_im[tw[j]]),
            .sum  (bf_sum[j]),
            .diff (bf_diff[j])
        );
    end

    always_comb begin
        stage_out = cur;
        for (int j = 0; j < NBF; j++) begin
            stage_out[ia[j]] = bf_sum[j];
            stage_out[ib[j]] = bf_diff[j];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ping-pong buffers
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `FFT_N; k++) begin
            load_frame[k].re = frame[k];
            load_frame[k].im = '0;  // real input
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_q[0] <= load_frame;
        end else if (state == RUN) begin
            buf_q[~rd_sel] <= stage_out;
        end
    end

endmodule

//--- rtl/spectrum_output.sv
// unscrambles bins and sends a real beat, then an imaginary beat
// output words are the integer part truncated to 16 bits, no saturation

`timescale 1ns/1ps

`include "fft16_settings.svh"

module spectrum_output
    import fft16_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  frame_t     res,
    input  logic       res_valid,
    output logic       res_ready,
    output out_frame_t out_data,
    output logic       out_imag,
    output logic       out_valid,
    input  logic       out_ready
);

    out_frame_t re_q;
    out_frame_t im_q;
    logic       take;

    function automatic logic [3:0] bit_rev(input logic [3:0] k);
        logic [3:0] r;
        for (int b = 0; b < 4; b++) begin
            r[b] = k[3-b];
        end
        return r;
    endfunction

    assign res_ready = !out_valid;    // empty only after both beats left
    assign take      = res_valid && res_ready;
    assign out_data  = out_imag ? im_q : re_q;

    ////////////////////////////////////////////////////////////////////////////
    // beat control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_imag  <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
            out_imag  <= 1'b0;
        end else if (out_valid && out_ready) begin
            if (!out_imag) begin
                out_imag <= 1'b1;
            end else begin
                out_valid <= 1'b0;
                out_imag  <= 1'b0;
            end
        end
    end

    // bin k lives at buffer index bitrev(k)
    always_ff @(posedge clk) begin
        if (take) begin
            for (int k = 0; k < `FFT_N; k++) begin
                re_q[k] <= res[bit_rev(4'(k))].re[`FFT_IN_SHIFT +: `FFT_IN_W];
                im_q[k] <= res[bit_rev(4'(k))].im[`FFT_IN_SHIFT +: `FFT_IN_W];
            end
        end
    end

endmodule

//--- rtl/fft16.sv
// 16-point real-input FFT with valid/ready on both sides
// up to three frames in flight, 6 cycle latency without back-pressure

`timescale 1ns/1ps

module fft16 (
    input  logic                 clk,
    input  logic                 rst,
    input  fft16_pkg::sample_t    in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    output fft16_pkg::out_frame_t out_data,
    output logic                 out_imag,
    output logic                 out_valid,
    input  logic                 out_ready
);

    fft16_pkg::real_frame_t frame;
    logic                   frame_valid;
    logic                   frame_ready;

    fft16_pkg::frame_t      res;
    logic                   res_valid;
    logic                   res_ready;

    sample_collector i_collector (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    fft_stage_engine i_engine (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready)
    );

    spectrum_output i_output (
        .clk       (clk),
        .rst       (rst),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .out_data  (out_data),
        .out_imag  (out_imag),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- dv/fft16_assert.sv
// handshake checks bound to the fft16 top level
// the drain bound holds only while out_ready stays high

`timescale 1ns/1ps

module fft16_assert
    import fft16_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       in_ready,
    input out_frame_t out_data,
    input logic       out_imag,
    input logic       out_valid,
    input logic       out_ready
);

    localparam int DRAIN_MAX = 16;  // cycles

    int fails = 0;

    // a waiting beat must not move
    hold_beat: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_imag))
        else begin
            $error("output beat changed before it was taken");
            fails++;
        end

    beat_order: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |=> out_imag != $past(out_imag))
        else begin
            $error("out_imag did not toggle after a transferred beat");
            fails++;
        end

    // with the sink open the pipeline must drain
    no_freeze: assert property (@(posedge clk) disable iff (rst)
        !in_ready && out_ready |-> ##[0:DRAIN_MAX] (in_ready || !out_ready))
        else begin
            $error("in_ready stayed low with out_ready high");
            fails++;
        end

endmodule

bind fft16 fft16_assert i_handshake_checks (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_imag  (out_imag),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

//--- dv/fft16_tb.sv
// directed tests against a bit-exact model of the fixed-point DIF stages
// every wait gives up after WAIT_LIMIT cycles

`timescale 1ns/1ps

`include "fft16_settings.svh"

module fft16_tb;
    import fft16_pkg::*;

    typedef out_word_t bins_t [`FFT_N];
    typedef sample_t   samples_t [`FFT_N];

    localparam int WAIT_LIMIT = 200;

    logic       clk;
    logic       rst;
    sample_t    in_data;
    logic       in_valid;
    logic       in_ready;
    out_frame_t out_data;
    logic       out_imag;
    logic       out_valid;
    logic       out_ready;

    int          errors;
    int          checks;
    int          tests;
    int          errors_at_start;
    string       cur_test;

    fft16 i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_imag  (out_imag),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;  // drive and sample away from the edge
    endtask

    task automatic abort_run(input string what);
        $display("timeout in %s: %s", cur_test, what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_value(input string what, input int expv, input int actv);
        checks++;
        assert (actv == expv) else begin
            $display("ERROR %s: %s expected %0d, actual %0d", cur_test, what, expv, actv);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %-12s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    function automatic int bit_reverse(input int k);
        int r;
        r = 0;
        for (int b = 0; b < `FFT_STAGES; b++) begin
            r = (r << 1) | ((k >> b) & 1);
        end
        return r;
    endfunction

    // Q.8 times Q16.16 floored back to Q.8
    function automatic word_t q16_floor(input word_t x, input word_t w);
        longint p;
        p = longint'(x) * longint'(w);
        return word_t'(p >>> `FFT_TW_FRAC);
    endfunction

    task automatic model_spectrum(input samples_t s, output bins_t re, output bins_t im);
        word_t xr [`FFT_N];
        word_t xi [`FFT_N];
        word_t dr;
        word_t di;
        int    span;
        int    m;
        int    k;
        for (int n = 0; n < `FFT_N; n++) begin
            xr[n] = word_t'(s[n]) * (1 << `FFT_IN_SHIFT);
            xi[n] = '0;
        end
        for (int st = 0; st < `FFT_STAGES; st++) begin
            span = (`FFT_N / 2) >> st;
            for (int n = 0; n < `FFT_N; n++) begin
                if ((n & span) == 0) begin  // upper element of a pair
                    m     = n + span;
                    k     = (n % span) * ((`FFT_N / 2) / span);
                    dr    = xr[n] - xr[m];
                    di    = xi[n] - xi[m];
                    xr[n] = xr[n] + xr[m];
                    xi[n] = xi[n] + xi[m];
                    xr[m] = q16_floor(dr, twiddle_re[k]) - q16_floor(di, twiddle_im[k]);
                    xi[m] = q16_floor(dr, twiddle_im[k]) + q16_floor(di, twiddle_re[k]);
                end
            end
        end
        for (int b = 0; b < `FFT_N; b++) begin
            re[b] = out_word_t'(xr[bit_reverse(b)] >>> `FFT_IN_SHIFT);
            im[b] = out_word_t'(xi[bit_reverse(b)] >>> `FFT_IN_SHIFT);
        end
    endtask

    task automatic random_samples(output samples_t s);
        for (int n = 0; n < `FFT_N; n++) begin
            s[n] = sample_t'(int'($urandom_range(4000)) - 2000);
        end
    endtask

    task automatic send_frame(input samples_t s);
        int wait_cnt;
        for (int n = 0; n < `FFT_N; n++) begin
            in_data  = s[n];
            in_valid = 1'b1;
            wait_cnt = 0;
            while (!in_ready && wait_cnt < WAIT_LIMIT) begin
                step();
                wait_cnt++;
            end
            if (!in_ready) begin
                abort_run("in_ready stayed low");
            end else begin
                step();
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_spectrum(output bins_t re, output bins_t im);
        int wait_cnt;
        for (int beat = 0; beat < 2; beat++) begin
            wait_cnt = 0;
            while (!(out_valid && out_ready) && wait_cnt < WAIT_LIMIT) begin
                step();
                wait_cnt++;
            end
            if (!(out_valid && out_ready)) begin
                abort_run("no output beat arrived");
            end else begin
                check_value("out_imag", beat, out_imag);
                for (int k = 0; k < `FFT_N; k++) begin
                    if (beat == 0) begin
                        re[k] = out_data[k];
                    end else begin
                        im[k] = out_data[k];
                    end
                end
                step();
            end
        end
    endtask

    task automatic compare_bins(input bins_t exp_re, input bins_t exp_im,
                                input bins_t got_re, input bins_t got_im);
        for (int k = 0; k < `FFT_N; k++) begin
            check_value($sformatf("real bin %0d", k), exp_re[k], got_re[k]);
            check_value($sformatf("imag bin %0d", k), exp_im[k], got_im[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state_check();
        begin_test("reset");
        check_value("in_ready", 1, in_ready);
        check_value("out_valid", 0, out_valid);
        end_test();
    endtask

    task automatic impulse_response();
        samples_t s;
        bins_t    exp_re;
        bins_t    exp_im;
        bins_t    got_re;
        bins_t    got_im;
        begin_test("impulse");
        for (int n = 0; n < `FFT_N; n++) begin
            s[n]      = (n == 0) ? 16'sd100 : 16'sd0;
            exp_re[n] = 16'sd100;
            exp_im[n] = 16'sd0;
        end
        send_frame(s);
        collect_spectrum(got_re, got_im);
        compare_bins(exp_re, exp_im, got_re, got_im);
        end_test();
    endtask

    // constant input lands in bin 0 and alternating sign in bin 8
    task automatic dc_and_nyquist();
        samples_t s;
        bins_t    exp_re;
        bins_t    exp_im;
        bins_t    got_re;
        bins_t    got_im;
        begin_test("dc_nyquist");
        for (int pass = 0; pass < 2; pass++) begin
            for (int n = 0; n < `FFT_N; n++) begin
                s[n]      = (pass == 1 && n % 2 == 1) ? -16'sd50 : 16'sd50;
                exp_re[n] = (n == pass * 8) ? 16'sd800 : 16'sd0;
                exp_im[n] = 16'sd0;
            end
            send_frame(s);
            collect_spectrum(got_re, got_im);
            compare_bins(exp_re, exp_im, got_re, got_im);
        end
        end_test();
    endtask

    task automatic random_frames();
        samples_t s;
        bins_t    exp_re;
        bins_t    exp_im;
        bins_t    got_re;
        bins_t    got_im;
        begin_test("random");
        for (int f = 0; f < 8; f++) begin
            random_samples(s);
            model_spectrum(s, exp_re, exp_im);
            send_frame(s);
            collect_spectrum(got_re, got_im);
            compare_bins(exp_re, exp_im, got_re, got_im);
        end
        end_test();
    endtask

    task automatic back_pressure();
        samples_t s [3];
        bins_t    exp_re;
        bins_t    exp_im;
        bins_t    got_re;
        bins_t    got_im;
        begin_test("backpressure");
        out_ready = 1'b0;
        for (int f = 0; f < 3; f++) begin
            random_samples(s[f]);
            send_frame(s[f]);
        end
        // collector, engine and output all full, so input stays stalled
        repeat (4) begin
            step();
            check_value("in_ready with every stage full", 0, in_ready);
        end
        out_ready = 1'b1;
        for (int f = 0; f < 3; f++) begin
            model_spectrum(s[f], exp_re, exp_im);
            collect_spectrum(got_re, got_im);
            compare_bins(exp_re, exp_im, got_re, got_im);
        end
        check_value("out_valid after last beat", 0, out_valid);
        end_test();
    endtask

    task automatic back_to_back_frames();
        samples_t a;
        samples_t b;
        bins_t    exp_re;
        bins_t    exp_im;
        bins_t    got_re [2];
        bins_t    got_im [2];
        begin_test("streaming");
        random_samples(a);
        random_samples(b);
        fork
            begin
                send_frame(a);
                send_frame(b);
            end
            begin
                collect_spectrum(got_re[0], got_im[0]);
                collect_spectrum(got_re[1], got_im[1]);
            end
        join
        model_spectrum(a, exp_re, exp_im);
        compare_bins(exp_re, exp_im, got_re[0], got_im[0]);
        model_spectrum(b, exp_re, exp_im);
        compare_bins(exp_re, exp_im, got_re[1], got_im[1]);
        end_test();
    endtask

    initial begin
        void'($urandom(12));
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cur_test  = "setup";
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        step();
        reset_state_check();
        impulse_response();
        dc_and_nyquist();
        random_frames();
        back_pressure();
        back_to_back_frames();
        errors = errors + i_dut.i_handshake_checks.fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- fft16.f
+incdir+include
rtl/fft16_pkg.sv
rtl/sample_collector.sv
rtl/butterfly.sv
rtl/fft_stage_engine.sv
rtl/spectrum_output.sv
rtl/fft16.sv
dv/fft16_assert.sv
dv/fft16_tb.sv

//--- Bender.yml
package:
  name: fft16

sources:
  - include_dirs:
      - include
    files:
      - rtl/fft16_pkg.sv
      - rtl/sample_collector.sv
      - rtl/butterfly.sv
      - rtl/fft_stage_engine.sv
      - rtl/spectrum_output.sv
      - rtl/fft16.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/fft16_assert.sv
      - dv/fft16_tb.sv
